/* spi_config.svh */
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

////////////////////////////////////////
// SPI DAC master build constants
////////////////////////////////////////

// Bits per SPI frame, DAC write word
`define SPI_WIDTH 32

// Width of the SCK half-period divider
`define SPI_DIV_WIDTH 8

// Divider value out of reset
// Half period of div+1 clocks, so 5 clocks here
`define SPI_DIV_RESET 4

// APB word address, four registers at 0x0..0xC
`define APB_ADDR_WIDTH 4

`endif

/* spi_bus_pkg.sv */
`include "spi_config.svh"

package spi_bus_pkg;

	////////////////////////////////////////
	// APB register map
	////////////////////////////////////////

	// Divider on write, divider plus status on read
	localparam logic [`APB_ADDR_WIDTH-1:0] REG_CTRL   = `APB_ADDR_WIDTH'('h0);
	// Raw 32-bit frame, write starts a transfer
	localparam logic [`APB_ADDR_WIDTH-1:0] REG_TX_RAW = `APB_ADDR_WIDTH'('h4);
	// Channel in [19:16], code in [15:0]
	localparam logic [`APB_ADDR_WIDTH-1:0] REG_TX_DAC = `APB_ADDR_WIDTH'('h8);
	// Received word, read only
	localparam logic [`APB_ADDR_WIDTH-1:0] REG_RX     = `APB_ADDR_WIDTH'('hC);

	// Status bits in REG_CTRL read data
	localparam int STAT_BUSY_BIT = 8;
	localparam int STAT_DONE_BIT = 9;

	// Shift engine states
	typedef enum logic [1:0] {
		TRIG_WAITING = 2'd0,
		SENDING      = 2'd1,
		DONE         = 2'd2
	} spi_state_e;

endpackage

/* dac_frame_pkg.sv */
package dac_frame_pkg;

	// Write input register and update DAC output
	localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;

	// Don't-care nibbles around the command, sent as zero
	localparam logic [3:0] DAC_PREFIX = 4'h0;
	localparam logic [3:0] DAC_PAD    = 4'h0;

	////////////////////////////////////////
	// DAC frame layout, MSB first on the wire
	////////////////////////////////////////

	typedef struct packed {
		logic [3:0]  prefix;
		logic [3:0]  cmd;
		logic [3:0]  addr;
		logic [15:0] code;
		logic [3:0]  pad;
	} dac_fields_t;

	// Same word seen as a shift frame or as DAC fields
	typedef union packed {
		logic [31:0] raw;
		dac_fields_t fields;
	} dac_frame_u;

endpackage

/* spi.sv */
`timescale 1ns/1ps

`include "spi_config.svh"

module spi #(
	parameter int WIDTH = `SPI_WIDTH
) (
	input  logic                   RST,
	input  logic                   CLK50MHZ,
	input  logic                   spi_sck_trig,
	input  logic                   SPI_MISO,
	output logic                   SPI_MOSI,
	input  logic [WIDTH-1:0]       data_in,
	output logic [WIDTH-1:0]       data_out,
	input  logic                   spi_trig,
	output logic                   spi_done,
	output spi_bus_pkg::spi_state_e state
);
	import spi_bus_pkg::*;

	// Tick counter must reach WIDTH, one past the last data bit
	localparam int CNT_W = $clog2(WIDTH + 1);
	localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(WIDTH);

	logic [WIDTH-1:0] out_shift;
	logic [WIDTH-1:0] in_shift;
	logic [CNT_W-1:0] tick_cnt;

	assign data_out = in_shift;
	assign spi_done = (state == DONE);

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state <= TRIG_WAITING;
		end else begin
			case (state)
				TRIG_WAITING:
					if (spi_trig)
						state <= SENDING;
				// WIDTH+1 ticks, the extra one covers the DAC readback slip
				SENDING:
					if (spi_sck_trig && tick_cnt == TICK_LAST)
						state <= DONE;
				DONE:
					state <= TRIG_WAITING;
				default:
					state <= TRIG_WAITING;
			endcase
		end
	end

	// MOSI register and tick count
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			tick_cnt <= '0;
			SPI_MOSI <= 1'b0;
		end else begin
			case (state)
				TRIG_WAITING: begin
					tick_cnt <= '0;
					SPI_MOSI <= 1'b0;
				end
				SENDING:
					if (spi_sck_trig) begin
						// MSB out, lands on the SCK falling edge
						SPI_MOSI <= out_shift[WIDTH-1];
						tick_cnt <= tick_cnt + CNT_W'(1);
					end
				default:
					SPI_MOSI <= 1'b0;
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge CLK50MHZ) begin
		if (state == TRIG_WAITING) begin
			out_shift <= data_in;
			// Old readback kept on data_out until the next start
			if (spi_trig)
				in_shift <= '0;
		end else if (state == SENDING && spi_sck_trig) begin
			out_shift <= {out_shift[WIDTH-2:0], 1'b0};
			in_shift  <= {in_shift[WIDTH-2:0], SPI_MISO};
		end
	end

	// Done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		spi_done |=> !spi_done)
		else $error("spi_done held longer than one cycle");

	// Register block never restarts a running frame
	a_no_trig_sending: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		spi_trig |-> state != SENDING)
		else $error("spi_trig while frame in progress");

endmodule

/* spi_bus_timing.sv */
`timescale 1ns/1ps

`include "spi_config.svh"

module spi_bus_timing (
	input  logic                       RST,
	input  logic                       CLK50MHZ,
	input  logic [`SPI_DIV_WIDTH-1:0]  div,
	input  spi_bus_pkg::spi_state_e     state,
	output logic                       spi_sck_trig,
	output logic                       SPI_SCK,
	output logic                       SPI_CS_N
);
	import spi_bus_pkg::*;

	// Clocks left in the current SCK half period
	logic [`SPI_DIV_WIDTH-1:0] half_cnt;
	// Phase, idles high so the first tick comes at frame start
	logic sck_hi;
	logic running;
	logic half_end;

	assign running  = (state == SENDING);
	assign half_end = (half_cnt == '0);

	// Tick at end of high phase, SCK falls on the same edge
	assign spi_sck_trig = running && half_end && sck_hi;

	// Chip select follows the engine state directly
	assign SPI_CS_N = !running;

	////////////////////////////////////////
	// SCK divider
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST || !running) begin
			half_cnt <= '0;
			sck_hi   <= 1'b1;
			SPI_SCK  <= 1'b0;
		end else if (half_end) begin
			// Each half lasts div+1 clocks
			half_cnt <= div;
			sck_hi   <= !sck_hi;
			SPI_SCK  <= !sck_hi;
		end else begin
			half_cnt <= half_cnt - `SPI_DIV_WIDTH'(1);
		end
	end

	// No SCK edges outside a selected frame
	a_sck_idle: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		SPI_CS_N |-> !SPI_SCK)
		else $error("SPI_SCK high with chip select released");

endmodule

/* spi_apb_regs.sv */
`timescale 1ns/1ps

`include "spi_config.svh"

module spi_apb_regs (
	input  logic                        RST,
	input  logic                        CLK50MHZ,
	input  logic                        PSEL,
	input  logic                        PENABLE,
	input  logic                        PWRITE,
	input  logic [`APB_ADDR_WIDTH-1:0]  PADDR,
	input  logic [31:0]                 PWDATA,
	output logic [31:0]                 PRDATA,
	output logic                        PREADY,
	output logic                        PSLVERR,
	input  logic [`SPI_WIDTH-1:0]       rx_data,
	input  logic                        spi_done,
	output logic [`SPI_WIDTH-1:0]       tx_data,
	output logic                        spi_trig,
	output logic [`SPI_DIV_WIDTH-1:0]   div
);
	import spi_bus_pkg::*;
	import dac_frame_pkg::*;

	logic                  busy;
	logic                  done_sticky;
	logic [`SPI_WIDTH-1:0] rx_reg;
	logic                  access;
	logic                  addr_hit;
	logic                  is_tx;
	logic                  tx_write;
	logic                  tx_accept;
	logic                  ctrl_write;
	logic                  rx_read;
	dac_frame_u            frame;

	////////////////////////////////////////
	// Address decode and handshake
	////////////////////////////////////////

	// Access phase of an APB transfer
	assign access = PSEL && PENABLE;

	assign addr_hit = (PADDR == REG_CTRL) || (PADDR == REG_TX_RAW) ||
		(PADDR == REG_TX_DAC) || (PADDR == REG_RX);
	assign is_tx = (PADDR == REG_TX_RAW) || (PADDR == REG_TX_DAC);

	assign tx_write   = access && PWRITE && is_tx;
	assign ctrl_write = access && PWRITE && (PADDR == REG_CTRL);
	assign rx_read    = access && !PWRITE && (PADDR == REG_RX);

	// Wait states only for a TX write during a frame
	assign PREADY    = !(tx_write && busy);
	assign tx_accept = tx_write && !busy;

	// Unmapped offset or write to the read-only RX word
	assign PSLVERR = access && (!addr_hit || (PWRITE && PADDR == REG_RX));

	// Frame word, DAC form built through the field view
	always_comb begin
		frame.raw = PWDATA;
		if (PADDR == REG_TX_DAC) begin
			frame.fields.prefix = DAC_PREFIX;
			frame.fields.cmd    = DAC_CMD_WRITE_UPDATE;
			frame.fields.addr   = PWDATA[19:16];
			frame.fields.code   = PWDATA[15:0];
			frame.fields.pad    = DAC_PAD;
		end
	end

	// Zero-wait read mux
	always_comb begin
		PRDATA = '0;
		if (access && !PWRITE) begin
			case (PADDR)
				REG_CTRL: begin
					PRDATA[`SPI_DIV_WIDTH-1:0] = div;
					PRDATA[STAT_BUSY_BIT]      = busy;
					PRDATA[STAT_DONE_BIT]      = done_sticky;
				end
				REG_TX_RAW, REG_TX_DAC:
					PRDATA = tx_data;
				REG_RX:
					PRDATA = rx_reg;
				default:
					PRDATA = '0;
			endcase
		end
	end

	////////////////////////////////////////
	// Control and status
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			div         <= `SPI_DIV_WIDTH'(`SPI_DIV_RESET);
			spi_trig    <= 1'b0;
			busy        <= 1'b0;
			done_sticky <= 1'b0;
		end else begin
			// Start one cycle after the accepted write
			spi_trig <= tx_accept;
			if (ctrl_write)
				div <= PWDATA[`SPI_DIV_WIDTH-1:0];
			if (spi_trig)
				busy <= 1'b1;
			else if (spi_done)
				busy <= 1'b0;
			// New completion wins over a clearing read
			if (spi_done)
				done_sticky <= 1'b1;
			else if (rx_read)
				done_sticky <= 1'b0;
		end
	end

	// Frame and readback words
	always_ff @(posedge CLK50MHZ) begin
		if (tx_accept)
			tx_data <= frame.raw;
		if (spi_done)
			rx_reg <= rx_data;
	end

	// Back-pressure keeps starts apart
	a_trig_idle: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		spi_trig |-> !busy)
		else $error("transfer started while busy");

endmodule

/* spi_dac_top.sv */
`timescale 1ns/1ps

`include "spi_config.svh"

module spi_dac_top (
	input  logic                        RST,
	input  logic                        CLK50MHZ,
	// APB slave
	input  logic                        PSEL,
	input  logic                        PENABLE,
	input  logic                        PWRITE,
	input  logic [`APB_ADDR_WIDTH-1:0]  PADDR,
	input  logic [31:0]                 PWDATA,
	output logic [31:0]                 PRDATA,
	output logic                        PREADY,
	output logic                        PSLVERR,
	// DAC pins
	output logic                        SPI_SCK,
	output logic                        SPI_CS_N,
	output logic                        SPI_MOSI,
	input  logic                        SPI_MISO
);
	import spi_bus_pkg::*;

	logic [`SPI_WIDTH-1:0]     tx_data;
	logic [`SPI_WIDTH-1:0]     rx_data;
	logic                      spi_trig;
	logic                      spi_done;
	logic                      spi_sck_trig;
	logic [`SPI_DIV_WIDTH-1:0] div;
	spi_state_e                state;

	// Register file and frame assembly
	spi_apb_regs i_spi_apb_regs (
		.RST      (RST),
		.CLK50MHZ (CLK50MHZ),
		.PSEL     (PSEL),
		.PENABLE  (PENABLE),
		.PWRITE   (PWRITE),
		.PADDR    (PADDR),
		.PWDATA   (PWDATA),
		.PRDATA   (PRDATA),
		.PREADY   (PREADY),
		.PSLVERR  (PSLVERR),
		.rx_data  (rx_data),
		.spi_done (spi_done),
		.tx_data  (tx_data),
		.spi_trig (spi_trig),
		.div      (div)
	);

	// SCK, chip select and shift ticks
	spi_bus_timing i_spi_bus_timing (
		.RST          (RST),
		.CLK50MHZ     (CLK50MHZ),
		.div          (div),
		.state        (state),
		.spi_sck_trig (spi_sck_trig),
		.SPI_SCK      (SPI_SCK),
		.SPI_CS_N     (SPI_CS_N)
	);

	spi #(
		.WIDTH (`SPI_WIDTH)
	) i_spi (
		.RST          (RST),
		.CLK50MHZ     (CLK50MHZ),
		.spi_sck_trig (spi_sck_trig),
		.SPI_MISO     (SPI_MISO),
		.SPI_MOSI     (SPI_MOSI),
		.data_in      (tx_data),
		.data_out     (rx_data),
		.spi_trig     (spi_trig),
		.spi_done     (spi_done),
		.state        (state)
	);

endmodule

/* tb_spi_dac.sv */
`timescale 1ns/1ps

`include "spi_config.svh"

module tb_spi_dac;
	import spi_bus_pkg::*;
	import dac_frame_pkg::*;

	localparam int NUM_TESTS = 6;

	logic                       RST;
	logic                       CLK50MHZ;
	logic                       PSEL;
	logic                       PENABLE;
	logic                       PWRITE;
	logic [`APB_ADDR_WIDTH-1:0] PADDR;
	logic [31:0]                PWDATA;
	logic [31:0]                PRDATA;
	logic                       PREADY;
	logic                       PSLVERR;
	logic                       SPI_SCK;
	logic                       SPI_CS_N;
	logic                       SPI_MOSI;
	logic                       SPI_MISO;

	// Stimulus table, kind 0 is raw and 1 is DAC
	int          div_tab [NUM_TESTS];
	int          kind_tab [NUM_TESTS];
	logic [31:0] wdata_tab [NUM_TESTS];
	logic [31:0] resp_tab [NUM_TESTS];
	logic [31:0] exp_mosi_tab [NUM_TESTS];
	logic [31:0] exp_rx_tab [NUM_TESTS];

	logic [31:0] lfsr_state = 32'h0560_754d;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	int          cur_div = `SPI_DIV_RESET;

	// DAC slave model state
	logic [31:0] resp_q [$];
	logic [31:0] cap_q [$];
	int          rise_q [$];
	logic [31:0] cur_resp = '0;
	logic [31:0] shift_in = '0;
	int          bit_idx = 0;
	int          rises = 0;
	bit          in_frame = 0;

	// SCK phase monitor
	logic        prev_sck = 1'b0;
	int          run_len = 0;
	bit          run_valid = 0;

	spi_dac_top i_spi_dac_top (
		.RST      (RST),
		.CLK50MHZ (CLK50MHZ),
		.PSEL     (PSEL),
		.PENABLE  (PENABLE),
		.PWRITE   (PWRITE),
		.PADDR    (PADDR),
		.PWDATA   (PWDATA),
		.PRDATA   (PRDATA),
		.PREADY   (PREADY),
		.PSLVERR  (PSLVERR),
		.SPI_SCK  (SPI_SCK),
		.SPI_CS_N (SPI_CS_N),
		.SPI_MOSI (SPI_MOSI),
		.SPI_MISO (SPI_MISO)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = !CLK50MHZ;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// Setup, access, then hold until PREADY
	task automatic apb_access(input logic wr, input logic [`APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int waits);
		waits = 0;
		@(posedge CLK50MHZ);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= wr;
		PADDR   <= addr;
		PWDATA  <= wdata;
		@(posedge CLK50MHZ);
		PENABLE <= 1'b1;
		// Slave outputs looked at mid-cycle
		@(negedge CLK50MHZ);
		while (!PREADY) begin
			waits++;
			@(negedge CLK50MHZ);
		end
		rdata = PRDATA;
		err   = PSLVERR;
		@(posedge CLK50MHZ);
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	// Poll status until the done flag shows up
	task automatic wait_frame_done();
		logic [31:0] rd;
		logic        err;
		int          w;
		rd = '0;
		while (!rd[STAT_DONE_BIT])
			apb_access(1'b0, REG_CTRL, '0, rd, err, w);
	endtask

	task automatic build_table();
		dac_frame_u f;
		logic [3:0]  chan;
		logic [15:0] code;
		int          sum;
		sum = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			div_tab[i]  = (i < 2) ? 0 : (i < 4) ? 4 : 9;
			kind_tab[i] = i % 2;
			resp_tab[i] = rand_bits(32);
			if (kind_tab[i] == 0) begin
				wdata_tab[i]    = rand_bits(32);
				exp_mosi_tab[i] = wdata_tab[i];
			end else begin
				chan = 4'(rand_bits(4));
				code = 16'(rand_bits(16));
				wdata_tab[i] = {12'h000, chan, code};
				f.raw           = '0;
				f.fields.prefix = 4'h0;
				f.fields.cmd    = 4'h3;
				f.fields.addr   = chan;
				f.fields.code   = code;
				f.fields.pad    = 4'h0;
				exp_mosi_tab[i] = f.raw;
			end
			exp_rx_tab[i] = resp_tab[i];
			sum += 2 * (div_tab[i] + 1) * 33 + 20;
		end
		// Two back-pressure frames at divider 1
		sum += 2 * (2 * 2 * 33 + 20);
		cycle_limit = 2 * sum + 100;
	endtask

	////////////////////////////////////////
	// DAC slave model
	////////////////////////////////////////

	always @(negedge SPI_CS_N) begin
		cur_resp = (resp_q.size() > 0) ? resp_q.pop_front() : '0;
		bit_idx  = 31;
		shift_in = '0;
		rises    = 0;
		in_frame = 1;
		SPI_MISO <= cur_resp[31];
	end

	// Next readback bit after each falling edge
	always @(negedge SPI_SCK) begin
		if (SPI_CS_N === 1'b0 && bit_idx > 0) begin
			bit_idx--;
			SPI_MISO <= cur_resp[bit_idx];
		end
	end

	always @(posedge SPI_SCK) begin
		if (SPI_CS_N === 1'b0) begin
			shift_in = {shift_in[30:0], SPI_MOSI};
			rises++;
		end
	end

	always @(posedge SPI_CS_N) begin
		if (in_frame) begin
			cap_q.push_back(shift_in);
			rise_q.push_back(rises);
			in_frame = 0;
		end
	end

	// Phase lengths between SCK edges inside a frame
	always @(negedge CLK50MHZ) begin
		if (SPI_SCK !== prev_sck) begin
			if (run_valid)
				check_value("SPI_SCK phase", run_len, cur_div + 1);
			run_len   = 1;
			run_valid = (SPI_CS_N === 1'b0);
		end else begin
			run_len++;
		end
		prev_sck = SPI_SCK;
	end

	// Watchdog
	always @(posedge CLK50MHZ) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d clock cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		logic        err;
		int          w;
		int          err_before;
		logic [31:0] frame_a;
		logic [31:0] frame_b;
		RST      = 1'b0;
		PSEL     = 1'b0;
		PENABLE  = 1'b0;
		PWRITE   = 1'b0;
		PADDR    = '0;
		PWDATA   = '0;
		SPI_MISO = 1'b0;
		build_table();
		repeat (3) @(posedge CLK50MHZ);
		RST <= 1'b1;

		// Reset values
		err_before = errors;
		@(negedge CLK50MHZ);
		check_value("SPI_CS_N", 32'(SPI_CS_N), 32'd1);
		check_value("SPI_SCK", 32'(SPI_SCK), 32'd0);
		apb_access(1'b0, REG_CTRL, '0, rd, err, w);
		check_value("PRDATA", rd, `SPI_DIV_RESET);
		apb_access(1'b1, REG_RX, 32'h1234, rd, err, w);
		check_value("PSLVERR", 32'(err), 32'd1);
		apb_access(1'b0, `APB_ADDR_WIDTH'('h2), '0, rd, err, w);
		check_value("PSLVERR", 32'(err), 32'd1);
		$display("test reset and errors: %s", (errors == err_before) ? "ok" : "bad");

		for (int i = 0; i < NUM_TESTS; i++) begin
			err_before = errors;
			apb_access(1'b1, REG_CTRL, div_tab[i], rd, err, w);
			cur_div = div_tab[i];
			apb_access(1'b0, REG_CTRL, '0, rd, err, w);
			check_value("PRDATA", rd, div_tab[i]);
			resp_q.push_back(resp_tab[i]);
			apb_access(1'b1, (kind_tab[i] == 0) ? REG_TX_RAW : REG_TX_DAC,
				wdata_tab[i], rd, err, w);
			check_value("PSLVERR", 32'(err), 32'd0);
			// Divider with busy set while the frame runs
			apb_access(1'b0, REG_CTRL, '0, rd, err, w);
			check_value("PRDATA", rd, 32'(div_tab[i]) | (32'd1 << STAT_BUSY_BIT));
			wait_frame_done();
			check_true(cap_q.size() == 1, "slave model did not capture exactly one frame");
			if (cap_q.size() > 0) begin
				check_value("SPI_MOSI frame", cap_q.pop_front(), exp_mosi_tab[i]);
				check_value("SPI_SCK rises", rise_q.pop_front(), 32);
			end
			apb_access(1'b0, REG_RX, '0, rd, err, w);
			check_value("PRDATA", rd, exp_rx_tab[i]);
			apb_access(1'b0, REG_CTRL, '0, rd, err, w);
			check_value("done_sticky", 32'(rd[STAT_DONE_BIT]), 32'd0);
			$display("test %0d div %0d %s frame: %s", i, div_tab[i],
				(kind_tab[i] == 0) ? "raw" : "dac", (errors == err_before) ? "ok" : "bad");
		end

		// Back-pressure on a second TX write
		err_before = errors;
		frame_a = rand_bits(32);
		frame_b = rand_bits(32);
		apb_access(1'b1, REG_CTRL, 32'd1, rd, err, w);
		cur_div = 1;
		resp_q.push_back(rand_bits(32));
		resp_q.push_back(resp_tab[0]);
		apb_access(1'b1, REG_TX_RAW, frame_a, rd, err, w);
		apb_access(1'b1, REG_TX_RAW, frame_b, rd, err, w);
		check_true(w > 0, "second TX write was accepted without wait states");
		check_true(cap_q.size() == 1, "second TX write was accepted before the first frame ended");
		apb_access(1'b0, REG_RX, '0, rd, err, w);
		wait_frame_done();
		check_true(cap_q.size() == 2, "slave model did not capture two frames");
		if (cap_q.size() == 2) begin
			check_value("SPI_MOSI frame", cap_q.pop_front(), frame_a);
			check_value("SPI_MOSI frame", cap_q.pop_front(), frame_b);
		end
		apb_access(1'b0, REG_RX, '0, rd, err, w);
		check_value("PRDATA", rd, resp_tab[0]);
		$display("test back-pressure: %s", (errors == err_before) ? "ok" : "bad");

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 2, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
spi_bus_pkg.sv
dac_frame_pkg.sv
spi.sv
spi_bus_timing.sv
spi_apb_regs.sv
spi_dac_top.sv
tb_spi_dac.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_spi_dac -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
